// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_uart_cmd_bridge
FILELIST   := sim.f
OBJ_DIR    := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "test passed" $(LOG) || (echo "simulation did not pass"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/clk_gen.sv ====
module clk_gen #(
  parameter int period_ns    = 10,
  parameter int reset_cycles = 16
) (
  output logic clk,
  output logic rst_n
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2.0) clk = ~clk;
  end

  // release just after an edge
  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

// ==== bench/remote_model.sv ====
module remote_model (
  input  logic       clk,
  input  logic       from_dut,
  output logic       to_dut,
  input  logic       inject_parity,
  input  logic       inject_frame,
  input  logic [6:0] mute_addr,
  output logic       frame_fault
);

  timeunit 1ns;
  timeprecision 100ps;

  import uart_pkg::*;
  import cmd_pkg::*;

  logic [7:0] regs [128];
  logic [7:0] head;
  logic [7:0] wdata;
  logic       bad_frame;
  logic [7:0] reply_data;
  logic       reply_req = 1'b0;

  // falling edges, away from the DUT's flop updates
  task automatic wait_clks(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic recv_frame(output logic [7:0] data, output logic bad);
    logic start_bit;
    logic par;
    logic stop;
    int   i;
    wait (from_dut === 1'b1);
    @(negedge from_dut);
    wait_clks(clks_per_bit / 2);
    start_bit = from_dut;
    for (i = 7; i >= 0; i--) begin
      wait_clks(clks_per_bit);
      data[i] = from_dut;
    end
    wait_clks(clks_per_bit);
    par = from_dut;
    wait_clks(clks_per_bit);
    stop = from_dut;
    bad = start_bit || !(^{data, par}) || !stop;
    if (bad) begin
      $display("remote model got a broken frame: data %h parity %b stop %b", data, par, stop);
    end
  endtask

  task automatic send_frame(input logic [7:0] data, input logic flip_par, input logic low_stop);
    logic [10:0] bits;
    int          i;
    bits = {1'b0, data, ~^data ^ flip_par, ~low_stop};
    for (i = 10; i >= 0; i--) begin
      to_dut = bits[i];
      wait_clks(clks_per_bit);
    end
    to_dut = 1'b1;
  endtask

  task automatic mark_fault();
    frame_fault = 1'b1;
    wait_clks(1);
    frame_fault = 1'b0;
  endtask

  // frame decoder and register file
  initial begin
    int a;
    frame_fault = 1'b0;
    for (a = 0; a < 128; a++) begin
      regs[a] = 8'(a * 37) ^ 8'hc3;
    end
    forever begin
      recv_frame(head, bad_frame);
      if (bad_frame) begin
        mark_fault();
      end
      if (cmd_op_e'(head[7]) == op_write) begin
        recv_frame(wdata, bad_frame);
        if (bad_frame) begin
          mark_fault();
        end
        regs[head[6:0]] = wdata;
      end else if (head[6:0] != mute_addr) begin
        reply_data = regs[head[6:0]];
        reply_req  = 1'b1;
      end
    end
  end

  // replier runs beside the decoder, two idle bits after the stop bit
  initial begin
    logic [7:0] data;
    to_dut = 1'b1;
    forever begin
      wait (reply_req);
      data      = reply_data;
      reply_req = 1'b0;
      wait_clks(clks_per_bit / 2 + 2 * clks_per_bit);
      send_frame(data, inject_parity, inject_frame);
    end
  end

endmodule

// ==== bench/tb_uart_cmd_bridge.sv ====
module tb_uart_cmd_bridge;

  timeunit 1ns;
  timeprecision 100ps;

  import uart_pkg::*;
  import cmd_pkg::*;

  localparam int n_pairs = 12;
  // random pairs plus parity, frame and mute cases
  localparam int n_trans = 2 * n_pairs + 5;
  localparam int reset_cycles = 16;
  localparam int cycle_limit =
    n_trans * (3 * frame_bits + reply_timeout_bits + 4) * clks_per_bit + reset_cycles + 200;
  localparam logic [6:0] mute_addr = 7'h7f;

  logic       clk;
  logic       rst_n;
  cmd_t       cmd;
  logic       cmd_valid;
  logic       cmd_ready;
  rsp_t       rsp;
  logic       rsp_valid;
  logic       rsp_ready;
  logic       tx;
  logic       rx;
  logic       inject_parity;
  logic       inject_frame;
  logic       frame_fault;

  logic [7:0] sb [128];
  rsp_t       exp_rsp;
  rsp_t       rsp_prev;
  logic       cmd_seen;
  logic       rsp_pending;
  int         seed = 32'h1ee9;
  int         cycles = 0;
  int         value_errs;
  int         proto_errs;

  clk_gen #(.period_ns(10), .reset_cycles(reset_cycles)) clk_gen_i (
    .clk   (clk),
    .rst_n (rst_n)
  );

  uart_cmd_bridge uart_cmd_bridge_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .tx        (tx),
    .rx        (rx)
  );

  remote_model remote_model_i (
    .clk           (clk),
    .from_dut      (tx),
    .to_dut        (rx),
    .inject_parity (inject_parity),
    .inject_frame  (inject_frame),
    .mute_addr     (mute_addr),
    .frame_fault   (frame_fault)
  );

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic issue_cmd(input cmd_op_e op, input logic [6:0] addr, input logic [7:0] data);
    cmd.op    = op;
    cmd.addr  = addr;
    cmd.data  = data;
    cmd_valid = 1'b1;
    cmd_seen  = 1'b1;
    while (!cmd_ready) begin
      tick();
    end
    tick();
    cmd_valid = 1'b0;
  endtask

  // random stall before taking the response
  task automatic take_rsp();
    int stall;
    while (!rsp_valid) begin
      tick();
    end
    stall = $random(seed) & 15;
    repeat (stall) tick();
    rsp_ready = 1'b1;
    tick();
    rsp_ready   = 1'b0;
    rsp_pending = 1'b0;
  endtask

  task automatic write_reg(input logic [6:0] addr, input logic [7:0] data);
    issue_cmd(op_write, addr, data);
    sb[addr] = data;
  endtask

  task automatic read_reg(input logic [6:0] addr, input rsp_t expected);
    exp_rsp     = expected;
    rsp_pending = 1'b1;
    issue_cmd(op_read, addr, 8'($random(seed)));
    take_rsp();
  endtask

  function automatic logic [6:0] rand_addr();
    logic [6:0] a;
    a = 7'($random(seed));
    return (a == mute_addr) ? 7'h00 : a;
  endfunction

  function automatic rsp_t clean_rsp(input logic [7:0] data);
    return '{data: data, parity_err: 1'b0, frame_err: 1'b0, timeout: 1'b0};
  endfunction

  always @(posedge clk) begin
    rsp_prev <= rsp;
  end

  after_reset_a: assert property (@(posedge clk) disable iff (!rst_n)
    !cmd_seen |-> tx && cmd_ready && !rsp_valid)
    else begin
      value_errs++;
      $display("** Error tx/cmd_ready/rsp_valid after reset: got %h/%h/%h expected 1/1/0",
               $sampled(tx), $sampled(cmd_ready), $sampled(rsp_valid));
    end

  rsp_data_a: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && rsp_ready |-> rsp.data == exp_rsp.data)
    else begin
      value_errs++;
      $display("** Error rsp.data: got %h expected %h",
               $sampled(rsp.data), $sampled(exp_rsp.data));
    end

  rsp_flags_a: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && rsp_ready |-> rsp[2:0] == exp_rsp[2:0])
    else begin
      value_errs++;
      $display("** Error rsp parity_err/frame_err/timeout: got %h/%h/%h expected %h/%h/%h",
               $sampled(rsp.parity_err), $sampled(rsp.frame_err), $sampled(rsp.timeout),
               $sampled(exp_rsp.parity_err), $sampled(exp_rsp.frame_err),
               $sampled(exp_rsp.timeout));
    end

  rsp_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && !rsp_ready |=> rsp_valid && rsp == rsp_prev)
    else begin
      value_errs++;
      $display("** Error rsp under back-pressure: held %h now %h, rsp_valid %h",
               $sampled(rsp_prev), $sampled(rsp), $sampled(rsp_valid));
    end

  busy_ready_a: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid |-> !cmd_ready)
    else begin
      value_errs++;
      $display("** Error cmd_ready: got %h expected 0", $sampled(cmd_ready));
    end

  rsp_expected_a: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid |-> rsp_pending)
    else begin
      proto_errs++;
      $display("response raised with no read outstanding");
    end

  tx_frame_a: assert property (@(posedge clk) disable iff (!rst_n) !frame_fault)
    else begin
      proto_errs++;
      $display("DUT sent a frame with wrong parity or a low stop bit");
    end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == cycle_limit) begin
      $display("run still busy after %0d cycles, stopping", cycles);
      $display("test failed");
      $finish;
    end
  end

  initial begin
    logic [6:0] addr;
    rsp_t       expect_rsp;
    cmd           = '0;
    cmd_valid     = 1'b0;
    rsp_ready     = 1'b0;
    inject_parity = 1'b0;
    inject_frame  = 1'b0;
    cmd_seen      = 1'b0;
    rsp_pending   = 1'b0;
    exp_rsp       = '0;
    value_errs    = 0;
    proto_errs    = 0;
    wait (rst_n);
    repeat (20) tick();

    for (int n = 0; n < n_pairs; n++) begin
      addr = rand_addr();
      write_reg(addr, 8'($random(seed)));
      read_reg(addr, clean_rsp(sb[addr]));
    end

    // corrupted reply parity
    addr = rand_addr();
    write_reg(addr, 8'($random(seed)));
    expect_rsp            = clean_rsp(sb[addr]);
    expect_rsp.parity_err = 1'b1;
    inject_parity         = 1'b1;
    read_reg(addr, expect_rsp);
    inject_parity = 1'b0;

    // low stop bit in the reply
    addr = rand_addr();
    write_reg(addr, 8'($random(seed)));
    expect_rsp           = clean_rsp(sb[addr]);
    expect_rsp.frame_err = 1'b1;
    inject_frame         = 1'b1;
    read_reg(addr, expect_rsp);
    inject_frame = 1'b0;

    // no reply at all
    expect_rsp         = clean_rsp(8'h00);
    expect_rsp.timeout = 1'b1;
    read_reg(mute_addr, expect_rsp);

    repeat (4) tick();
    $display("errors: %0d value, %0d protocol", value_errs, proto_errs);
    if (value_errs == 0 && proto_errs == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== design/cmd_pkg.sv ====
package cmd_pkg;

  // msb of a command word
  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } cmd_op_e;

  // host command, 16 bits
  typedef struct packed {
    cmd_op_e    op;
    logic [6:0] addr;
    logic [7:0] data;
  } cmd_t;

  // read response, 11 bits
  typedef struct packed {
    logic [7:0] data;
    logic       parity_err;
    logic       frame_err;
    logic       timeout;
  } rsp_t;

  // bit periods a read waits for the reply
  localparam int reply_timeout_bits = 24;

  localparam int reply_timeout_cycles = reply_timeout_bits * uart_pkg::clks_per_bit;
  localparam int timer_w = $clog2(reply_timeout_cycles + 1);

endpackage

// ==== design/cmd_sequencer.sv ====
module cmd_sequencer (
  input  logic               clk,
  input  logic               rst_n,
  input  cmd_pkg::cmd_t      cmd,
  input  logic               cmd_valid,
  output logic               cmd_ready,
  output cmd_pkg::rsp_t      rsp,
  output logic               rsp_valid,
  input  logic               rsp_ready,
  output logic [7:0]         tx_byte,
  output logic               tx_valid,
  input  logic               tx_ready,
  input  uart_pkg::rx_byte_t rx_byte,
  input  logic               rx_valid
);

  import cmd_pkg::*;

  typedef enum logic [2:0] {
    idle,
    send_addr,
    send_data,
    wait_reply,
    respond
  } state_e;

  state_e             state;
  cmd_t               cmd_q;
  rsp_t               rsp_q;
  // current byte handed to the transmitter
  logic               sent;
  logic [timer_w-1:0] timer;
  logic               timed_out;

  assign cmd_ready = (state == idle);
  assign rsp_valid = (state == respond);
  assign rsp       = rsp_q;
  assign tx_valid  = (state == send_addr || state == send_data) && !sent;
  assign timed_out = (timer == timer_w'(reply_timeout_cycles - 1));

  always_comb begin
    case (state)
      send_data: tx_byte = cmd_q.data;
      default:   tx_byte = {cmd_q.op, cmd_q.addr};
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= idle;
      sent  <= 1'b0;
      timer <= '0;
    end else begin
      case (state)
        idle: begin
          sent <= 1'b0;
          if (cmd_valid) begin
            state <= send_addr;
          end
        end
        send_addr: begin
          if (tx_valid && tx_ready) begin
            // write data byte queues behind the address frame
            if (cmd_q.op == op_write) begin
              state <= send_data;
            end else begin
              sent <= 1'b1;
            end
          end else if (sent && tx_ready) begin
            // reply wait starts once the address frame is out
            sent  <= 1'b0;
            timer <= '0;
            state <= wait_reply;
          end
        end
        send_data: begin
          if (tx_valid && tx_ready) begin
            sent <= 1'b1;
          end else if (sent && tx_ready) begin
            sent  <= 1'b0;
            state <= idle;
          end
        end
        wait_reply: begin
          if (rx_valid || timed_out) begin
            state <= respond;
          end else begin
            timer <= timer + 1'b1;
          end
        end
        respond: begin
          if (rsp_ready) begin
            state <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // stray bytes outside wait_reply fall through
  always_ff @(posedge clk) begin
    if (cmd_valid && cmd_ready) begin
      cmd_q <= cmd;
    end
    if (state == wait_reply) begin
      if (rx_valid) begin
        rsp_q <= '{data: rx_byte.data, parity_err: rx_byte.parity_err,
                   frame_err: rx_byte.frame_err, timeout: 1'b0};
      end else if (timed_out) begin
        rsp_q <= '{data: 8'h00, parity_err: 1'b0, frame_err: 1'b0, timeout: 1'b1};
      end
    end
  end

  rsp_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp) && !cmd_ready);

  // no new command while a frame is still on the line
  one_cmd_a: assert property (@(posedge clk) disable iff (!rst_n)
    !tx_ready |-> !cmd_ready);

endmodule

// ==== design/uart_cmd_bridge.sv ====
module uart_cmd_bridge (
  input  logic          clk,
  input  logic          rst_n,
  input  cmd_pkg::cmd_t cmd,
  input  logic          cmd_valid,
  output logic          cmd_ready,
  output cmd_pkg::rsp_t rsp,
  output logic          rsp_valid,
  input  logic          rsp_ready,
  output logic          tx,
  input  logic          rx
);

  import uart_pkg::*;

  logic [7:0] tx_byte;
  logic       tx_valid;
  logic       tx_ready;
  rx_byte_t   rx_byte;
  logic       rx_valid;

  cmd_sequencer cmd_sequencer_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .tx_byte   (tx_byte),
    .tx_valid  (tx_valid),
    .tx_ready  (tx_ready),
    .rx_byte   (rx_byte),
    .rx_valid  (rx_valid)
  );

  uart_tx uart_tx_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_byte  (tx_byte),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready),
    .tx       (tx)
  );

  // free-running, no back-pressure on the line
  uart_rx uart_rx_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .rx_byte  (rx_byte),
    .rx_valid (rx_valid)
  );

endmodule

// ==== design/uart_pkg.sv ====
package uart_pkg;

  // clock cycles per serial bit
  // a board build at 115200 baud from 50 MHz would use 434
  localparam int clks_per_bit = 16;

  // start, eight data bits, parity, stop
  localparam int frame_bits = 11;

  // bit-period counter and bit index widths
  localparam int cnt_w = $clog2(clks_per_bit);
  localparam int idx_w = $clog2(frame_bits);

  // one received frame with its line checks
  typedef struct packed {
    logic [7:0] data;
    // data plus parity hold an even number of ones
    logic       parity_err;
    // stop bit sampled low
    logic       frame_err;
  } rx_byte_t;

endpackage

// ==== design/uart_rx.sv ====
module uart_rx (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               rx,
  output uart_pkg::rx_byte_t rx_byte,
  output logic               rx_valid
);

  import uart_pkg::*;

  typedef enum logic [1:0] {
    idle,
    start,
    sample
  } state_e;

  state_e           state;
  logic             rx_meta;
  logic             rx_sync;
  logic             rx_prev;
  logic [cnt_w-1:0] cnt;
  logic [idx_w-1:0] bit_idx;
  // eight data bits then parity
  logic [8:0]       shreg;
  logic             fall;
  logic             sample_tick;
  logic             stop_tick;

  assign fall        = rx_prev && !rx_sync;
  assign sample_tick = (state == sample) && (cnt == cnt_w'(clks_per_bit - 1));
  assign stop_tick   = sample_tick && (bit_idx == idx_w'(frame_bits - 2));

  // two-flop synchronizer plus one for edge detect
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= idle;
      cnt      <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= stop_tick;
      case (state)
        idle: begin
          if (fall) begin
            cnt   <= '0;
            state <= start;
          end
        end
        start: begin
          // recheck at mid start bit, drop glitches
          if (cnt == cnt_w'(clks_per_bit / 2 - 1)) begin
            cnt     <= '0;
            bit_idx <= '0;
            state   <= rx_sync ? idle : sample;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        sample: begin
          if (sample_tick) begin
            cnt     <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (stop_tick) begin
              state <= idle;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (sample_tick && !stop_tick) begin
      shreg <= {shreg[7:0], rx_sync};
    end
    if (stop_tick) begin
      rx_byte.data       <= shreg[8:1];
      rx_byte.parity_err <= ~^shreg;
      rx_byte.frame_err  <= ~rx_sync;
    end
  end

  rx_valid_pulse_a: assert property (@(posedge clk) disable iff (!rst_n)
    rx_valid |=> !rx_valid);

endmodule

// ==== design/uart_tx.sv ====
module uart_tx (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [7:0] tx_byte,
  input  logic       tx_valid,
  output logic       tx_ready,
  output logic       tx
);

  import uart_pkg::*;

  typedef enum logic {
    idle,
    shift
  } state_e;

  state_e           state;
  logic [cnt_w-1:0] cnt;
  logic [idx_w-1:0] bit_idx;
  // data msb first, then parity and stop
  logic [9:0]       shreg;
  logic             last_tick;

  assign tx_ready  = (state == idle);
  assign last_tick = (cnt == cnt_w'(clks_per_bit - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= idle;
      cnt     <= '0;
      bit_idx <= '0;
      tx      <= 1'b1;
    end else begin
      case (state)
        idle: begin
          if (tx_valid) begin
            // start bit goes out right away
            tx      <= 1'b0;
            cnt     <= '0;
            bit_idx <= '0;
            state   <= shift;
          end
        end
        shift: begin
          if (last_tick) begin
            cnt <= '0;
            if (bit_idx == idx_w'(frame_bits - 1)) begin
              state <= idle;
              tx    <= 1'b1;
            end else begin
              tx      <= shreg[9];
              bit_idx <= bit_idx + 1'b1;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // odd parity over the data byte
  always_ff @(posedge clk) begin
    if (tx_valid && tx_ready) begin
      shreg <= {tx_byte, ~^tx_byte, 1'b1};
    end else if (state == shift && last_tick) begin
      shreg <= {shreg[8:0], 1'b1};
    end
  end

  tx_byte_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    tx_valid && !tx_ready |=> tx_valid && $stable(tx_byte));

endmodule

// ==== sim.f ====
design/uart_pkg.sv
design/cmd_pkg.sv
design/uart_tx.sv
design/uart_rx.sv
design/cmd_sequencer.sv
design/uart_cmd_bridge.sv
bench/clk_gen.sv
bench/remote_model.sv
bench/tb_uart_cmd_bridge.sv
